// ==== hdl/csc_cfg.svh ====
// tile geometry, converter mode codes, JP4DIFF delay length and register map
`ifndef CSC_CFG_SVH
`define CSC_CFG_SVH

// macroblock geometry, luma only
`define CSC_TILE_PIX 256
`define CSC_TILE_W 16

// converter_type codes, same numbering as the camera firmware
`define CSC_MODE_MONO16 3'd2
`define CSC_MODE_JP4 3'd3
`define CSC_MODE_JP4DIFF 3'd4

// one row plus one pixel, worst case distance to the cell base
`define CSC_DIFF_DELAY 17

// APB register map
`define CSC_REG_CTRL 4'h0

`endif

// ==== hdl/csc_pkg.sv ====
// csc_pkg: pixel, sample, address, counter, bayer phase and mode types
`include "csc_cfg.svh"

package csc_pkg;

    typedef logic [7:0] pix_t;            // raw bayer pixel
    typedef logic signed [8:0] ssample_t; // signed output sample
    typedef logic [7:0] yaddr_t;          // tile buffer address
    typedef logic [7:0] cnt_t;            // saturating pixel count
    typedef logic [1:0] bayer_t;          // bayer phase / color index

    // only these three converters exist, other codes disable output
    typedef enum logic [2:0] {
        MODE_MONO16  = `CSC_MODE_MONO16,
        MODE_JP4     = `CSC_MODE_JP4,
        MODE_JP4DIFF = `CSC_MODE_JP4DIFF
    } csc_mode_t;

endpackage

// ==== hdl/csc_apb_regs.sv ====
// csc_apb_regs: APB slave with the converter control register
`include "csc_cfg.svh"

module csc_apb_regs import csc_pkg::*; (
    input  logic        xclk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output csc_mode_t   converter_type,
    output logic        scale_diff,
    output logic        hdr,
    output logic        frame_en,
    output bayer_t      bayer_phase
);

    logic [31:0] ctrl_q;   // whole CTRL word, read back as written
    logic        hit_ctrl;
    logic        access;

    assign hit_ctrl = (paddr == `CSC_REG_CTRL);
    assign access   = psel & penable;   // second cycle of a transfer

    // no wait states
    assign pready  = 1'b1;
    assign pslverr = access & ~hit_ctrl;

    // read mux, one register only
    assign prdata = (psel && hit_ctrl) ? ctrl_q : '0;

    always_ff @(posedge xclk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '0;
        end else if (access && pwrite && hit_ctrl) begin
            ctrl_q <= pwdata;   // takes effect on the access edge
        end
    end

    // field decode
    // converter_type is sampled per tile by csconvert, illegal codes just disable it
    assign converter_type = csc_mode_t'(ctrl_q[2:0]);
    assign scale_diff     = ctrl_q[4];   // halve differences
    assign hdr            = ctrl_q[5];   // second green absolute
    assign bayer_phase    = ctrl_q[9:8];
    assign frame_en       = ctrl_q[31];

endmodule

// ==== hdl/csc_mono16.sv ====
// csc_mono16: MONO16 converter, signed luma with linear tile addresses
`include "csc_cfg.svh"

module csc_mono16 import csc_pkg::*; (
    input  logic     xclk,
    input  logic     rst_n,
    input  logic     en,
    input  logic     pre_first_in,
    input  pix_t     din,
    output ssample_t y_out,
    output yaddr_t   yaddr,
    output logic     ywe,
    output logic     pre_first_out
);

    yaddr_t cnt;      // index of the pixel now on din
    logic   active;   // din carries a tile pixel
    logic   pfo_q;

    // pixel counter, restarted by every tile start
    // en is only valid from the first pixel on, so it does not gate the restart
    always_ff @(posedge xclk or negedge rst_n) begin
        if (!rst_n) begin
            cnt    <= '0;
            active <= 1'b0;
        end else if (pre_first_in) begin
            cnt    <= '0;
            active <= 1'b1;
        end else if (active) begin
            cnt    <= cnt + 1'b1;
            active <= (cnt != yaddr_t'(`CSC_TILE_PIX - 1)); // stop after last
        end
    end

    always_ff @(posedge xclk or negedge rst_n) begin
        if (!rst_n) begin
            ywe   <= 1'b0;
            pfo_q <= 1'b0;
        end else begin
            ywe   <= en & active;
            pfo_q <= pre_first_in;
        end
    end

    // payload
    always_ff @(posedge xclk) begin
        y_out <= $signed({1'b0, din}) - 9'sd128;  // 0..255 -> -128..127
        yaddr <= cnt;                             // row*16+col is the index itself
    end

    // enable of the new tile is known one cycle after pre_first_in
    assign pre_first_out = pfo_q & en;

endmodule

// ==== hdl/csc_jp4.sv ====
// csc_jp4: JP4 bayer regrouping and JP4DIFF base color differences
`include "csc_cfg.svh"

module csc_jp4 import csc_pkg::*; (
    input  logic     xclk,
    input  logic     rst_n,
    input  logic     en,
    input  logic     diff_mode,
    input  logic     scale_diff,
    input  logic     hdr,
    input  logic     pre_first_in,
    input  bayer_t   bayer_phase,
    input  pix_t     din,
    output ssample_t y_out,
    output yaddr_t   yaddr,
    output logic     ywe,
    output logic     pre_first_out
);

    localparam int DL = `CSC_DIFF_DELAY;
    localparam int RB = $clog2(`CSC_TILE_W);   // column bits of the pixel index

    yaddr_t     cnt;
    logic       active;
    logic [3:0] row;
    logic [3:0] col;
    bayer_t     clr;       // color index of din
    yaddr_t     in_addr;   // {color, row/2, col/2}
    logic       in_base;   // din is a cell base in diff mode

    // JP4 path, one register stage
    ssample_t   jp4_y;
    yaddr_t     jp4_addr;
    logic       jp4_we;
    logic       jp4_pfo;

    // JP4DIFF delay line, payload carries its own tile flags
    pix_t       dl_pix  [DL];
    yaddr_t     dl_addr [DL];
    logic       dl_sd   [DL];
    logic       dl_hdr  [DL];
    logic [DL-1:0] dl_vld;
    logic [DL-1:0] dl_pfo;

    pix_t       base_mem [2][8];   // bank per row pair parity, entry per column pair
    pix_t       o_pix;
    yaddr_t     o_addr;
    pix_t       o_base;
    ssample_t   o_abs;
    ssample_t   o_dif;
    ssample_t   diff_y;

    always_ff @(posedge xclk or negedge rst_n) begin
        if (!rst_n) begin
            cnt    <= '0;
            active <= 1'b0;
        end else if (pre_first_in) begin
            cnt    <= '0;
            active <= 1'b1;
        end else if (active) begin
            cnt    <= cnt + 1'b1;
            active <= (cnt != yaddr_t'(`CSC_TILE_PIX - 1));
        end
    end

    assign row     = cnt[7:RB];
    assign col     = cnt[RB-1:0];
    assign clr     = {row[0], col[0]} ^ bayer_phase;
    assign in_addr = {clr, row[3:1], col[3:1]};
    assign in_base = en & diff_mode & active & (clr == 2'd0);

    always_ff @(posedge xclk or negedge rst_n) begin
        if (!rst_n) begin
            jp4_we  <= 1'b0;
            jp4_pfo <= 1'b0;
            dl_vld  <= '0;
            dl_pfo  <= '0;
        end else begin
            jp4_we  <= en & ~diff_mode & active;
            jp4_pfo <= pre_first_in;
            dl_vld  <= {dl_vld[DL-2:0], en & diff_mode & active};
            dl_pfo  <= {dl_pfo[DL-2:0], pre_first_in};
        end
    end

    always_ff @(posedge xclk) begin
        jp4_y    <= $signed({1'b0, din}) - 9'sd128;
        jp4_addr <= in_addr;
        dl_pix[0]  <= din;
        dl_addr[0] <= in_addr;
        dl_sd[0]   <= scale_diff;
        dl_hdr[0]  <= hdr;
        for (int i = 1; i < DL; i++) begin
            dl_pix[i]  <= dl_pix[i-1];
            dl_addr[i] <= dl_addr[i-1];
            dl_sd[i]   <= dl_sd[i-1];
            dl_hdr[i]  <= dl_hdr[i-1];
        end
        if (in_base) begin
            base_mem[row[1]][col[3:1]] <= din;
        end
    end

    assign o_pix  = dl_pix[DL-1];
    assign o_addr = dl_addr[DL-1];

    // phase 3 puts the base 17 pixels after the cell's first pixel,
    // it is on din exactly when that pixel leaves the line
    assign o_base = (in_base && in_addr[5:0] == o_addr[5:0]) ? din
                                                             : base_mem[o_addr[3]][o_addr[2:0]];

    assign o_abs = $signed({1'b0, o_pix}) - 9'sd128;
    assign o_dif = $signed({1'b0, o_pix}) - $signed({1'b0, o_base});   // -255..255

    always_comb begin
        if (o_addr[7:6] == 2'd0 || (dl_hdr[DL-1] && o_addr[7:6] == 2'd3)) begin
            diff_y = o_abs;        // base, or hdr green
        end else if (dl_sd[DL-1]) begin
            diff_y = o_dif >>> 1;  // fits 8-bit range
        end else begin
            diff_y = o_dif;
        end
    end

    // only one of the two paths carries a tile at a time
    assign ywe   = jp4_we | dl_vld[DL-1];
    assign y_out = dl_vld[DL-1] ? diff_y : jp4_y;
    assign yaddr = dl_vld[DL-1] ? o_addr : jp4_addr;

    // en still belongs to the same tile 17 cycles after its start
    assign pre_first_out = en & (diff_mode ? dl_pfo[DL-1] : jp4_pfo);

endmodule

// ==== hdl/csconvert.sv ====
// csconvert: per-tile mode capture, converter enables, output mux and black/white counters
`include "csc_cfg.svh"

module csconvert import csc_pkg::*; (
    input  logic      xclk,
    input  logic      rst_n,
    input  logic      frame_en,
    input  logic      pre_first_in,
    input  csc_mode_t converter_type,
    input  logic      scale_diff,
    input  logic      hdr,
    input  bayer_t    bayer_phase,
    input  pix_t      mb_din,
    output ssample_t  signed_y,
    output yaddr_t    yaddrw,
    output logic      ywe,
    output logic      pre_first_out,
    output cnt_t      n000,
    output cnt_t      n255
);

    logic     en_mono;
    logic     en_jp4;
    logic     en_diff;
    logic     scale_diff_r;
    logic     hdr_r;
    bayer_t   bayer_phase_r;

    ssample_t mono_y;
    yaddr_t   mono_addr;
    logic     mono_we;
    logic     mono_pfo;
    ssample_t jp4_y;
    yaddr_t   jp4_addr;
    logic     jp4_we;
    logic     jp4_pfo;
    yaddr_t   sel_addr;

    yaddr_t   pix_cnt;    // tile pixel index for the counters
    logic     pix_act;
    logic     last_pix;
    cnt_t     acc000;
    cnt_t     acc255;

    // tile settings, sampled once per tile
    always_ff @(posedge xclk or negedge rst_n) begin
        if (!rst_n) begin
            scale_diff_r  <= 1'b0;
            hdr_r         <= 1'b0;
            bayer_phase_r <= '0;
        end else if (pre_first_in) begin
            scale_diff_r  <= scale_diff;
            hdr_r         <= hdr;
            bayer_phase_r <= bayer_phase;
        end
    end

    // one-hot enables, cleared at once when the frame is stopped
    always_ff @(posedge xclk or negedge rst_n) begin
        if (!rst_n) begin
            en_mono <= 1'b0;
            en_jp4  <= 1'b0;
            en_diff <= 1'b0;
        end else if (!frame_en) begin
            en_mono <= 1'b0;
            en_jp4  <= 1'b0;
            en_diff <= 1'b0;
        end else if (pre_first_in) begin
            en_mono <= (converter_type == MODE_MONO16);
            en_jp4  <= (converter_type == MODE_JP4);
            en_diff <= (converter_type == MODE_JP4DIFF);
        end
    end

    csc_mono16 i_mono16 (
        .xclk          (xclk),
        .rst_n         (rst_n),
        .en            (en_mono),
        .pre_first_in  (pre_first_in),
        .din           (mb_din),
        .y_out         (mono_y),
        .yaddr         (mono_addr),
        .ywe           (mono_we),
        .pre_first_out (mono_pfo)
    );

    // one instance for JP4 and JP4DIFF
    csc_jp4 i_jp4 (
        .xclk          (xclk),
        .rst_n         (rst_n),
        .en            (en_jp4 | en_diff),
        .diff_mode     (en_diff),
        .scale_diff    (scale_diff_r),
        .hdr           (hdr_r),
        .pre_first_in  (pre_first_in),
        .bayer_phase   (bayer_phase_r),
        .din           (mb_din),
        .y_out         (jp4_y),
        .yaddr         (jp4_addr),
        .ywe           (jp4_we),
        .pre_first_out (jp4_pfo)
    );

    // pick by write enable so a JP4DIFF tail survives a mode change
    assign sel_addr = mono_we ? mono_addr : jp4_addr;

    always_ff @(posedge xclk or negedge rst_n) begin
        if (!rst_n) begin
            ywe           <= 1'b0;
            pre_first_out <= 1'b0;
        end else begin
            ywe           <= mono_we | jp4_we;
            pre_first_out <= mono_pfo | jp4_pfo;
        end
    end

    always_ff @(posedge xclk) begin
        signed_y <= mono_we ? mono_y : jp4_y;
        yaddrw   <= {sel_addr[7], sel_addr[3], sel_addr[6:4], sel_addr[2:0]}; // buffer layout
    end

    // black / white statistics over the input tile
    always_ff @(posedge xclk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt  <= '0;
            pix_act  <= 1'b0;
            last_pix <= 1'b0;
        end else begin
            last_pix <= pix_act && (pix_cnt == yaddr_t'(`CSC_TILE_PIX - 1));
            if (pre_first_in) begin
                pix_cnt <= '0;
                pix_act <= 1'b1;
            end else if (pix_act) begin
                pix_cnt <= pix_cnt + 1'b1;
                pix_act <= (pix_cnt != yaddr_t'(`CSC_TILE_PIX - 1));
            end
        end
    end

    always_ff @(posedge xclk or negedge rst_n) begin
        if (!rst_n) begin
            acc000 <= '0;
            acc255 <= '0;
            n000   <= '0;
            n255   <= '0;
        end else begin
            if (pix_act && pix_cnt == '0) begin   // first pixel restarts
                acc000 <= cnt_t'(mb_din == 8'h00);
                acc255 <= cnt_t'(mb_din == 8'hff);
            end else if (pix_act) begin
                if (mb_din == 8'h00 && acc000 != 8'hff) begin
                    acc000 <= acc000 + 1'b1;      // saturates at 255
                end
                if (mb_din == 8'hff && acc255 != 8'hff) begin
                    acc255 <= acc255 + 1'b1;
                end
            end
            if (last_pix) begin   // publish, held till next tile
                n000 <= acc000;
                n255 <= acc255;
            end
        end
    end

endmodule

// ==== hdl/csc_top.sv ====
// csc_top: APB control registers and color converter
module csc_top import csc_pkg::*; (
    input  logic        xclk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        pre_first_in,
    input  pix_t        mb_din,
    output ssample_t    signed_y,
    output yaddr_t      yaddrw,
    output logic        ywe,
    output logic        pre_first_out,
    output cnt_t        n000,
    output cnt_t        n255
);

    csc_mode_t converter_type;
    logic      scale_diff;
    logic      hdr;
    logic      frame_en;
    bayer_t    bayer_phase;

    csc_apb_regs i_regs (
        .xclk           (xclk),
        .rst_n          (rst_n),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .converter_type (converter_type),
        .scale_diff     (scale_diff),
        .hdr            (hdr),
        .frame_en       (frame_en),
        .bayer_phase    (bayer_phase)
    );

    csconvert i_csconvert (
        .xclk           (xclk),
        .rst_n          (rst_n),
        .frame_en       (frame_en),
        .pre_first_in   (pre_first_in),
        .converter_type (converter_type),
        .scale_diff     (scale_diff),
        .hdr            (hdr),
        .bayer_phase    (bayer_phase),
        .mb_din         (mb_din),
        .signed_y       (signed_y),
        .yaddrw         (yaddrw),
        .ywe            (ywe),
        .pre_first_out  (pre_first_out),
        .n000           (n000),
        .n255           (n255)
    );

endmodule

// ==== dv/csc_assert.sv ====
// csc_assert: bound protocol checks on APB ready and tile output framing
module csc_assert (
    input logic xclk,
    input logic rst_n,
    input logic psel,
    input logic pready,
    input logic ywe,
    input logic pre_first_out
);
    timeunit 1ns;
    timeprecision 1ps;

    int n_fail = 0;   // failed assertion count

    // no wait states on the register bus
    assert property (@(posedge xclk) disable iff (!rst_n) psel |-> pready)
        else begin
            $error("pready low during a selected APB cycle");
            n_fail++;
        end

    // a write burst always opens with the tile start pulse
    assert property (@(posedge xclk) disable iff (!rst_n) $rose(ywe) |-> $past(pre_first_out))
        else begin
            $error("ywe rose without pre_first_out in the cycle before");
            n_fail++;
        end

    assert property (@(posedge xclk) disable iff (!rst_n) pre_first_out |=> !pre_first_out)
        else begin
            $error("pre_first_out longer than one cycle");
            n_fail++;
        end

endmodule

bind csc_top csc_assert i_assert (
    .xclk          (xclk),
    .rst_n         (rst_n),
    .psel          (psel),
    .pready        (pready),
    .ywe           (ywe),
    .pre_first_out (pre_first_out)
);

// ==== dv/csc_tb.sv ====
// csc_tb: clock, APB driver, stimulus reader, reference model, checks and watchdog
`include "csc_cfg.svh"

module csc_tb import csc_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD = 100;

    logic xclk, rst_n, psel, penable, pwrite, pre_first_in;
    logic [3:0] paddr;
    logic [31:0] pwdata, prdata;
    logic pready, pslverr, ywe, pre_first_out;
    pix_t mb_din;
    ssample_t signed_y;
    yaddr_t yaddrw;
    cnt_t n000, n255;

    int n_tiles;
    logic [31:0] t_ctrl [64];
    logic [31:0] t_seed [64];
    int t_src [64];
    bit t_b2b [64];
    pix_t pix [256];
    int exp_addr[$];
    int exp_val[$];
    int hit [256];
    int tile_wr, pfo_seen, pfo_exp, errors, cur0, cur255;

    csc_top i_dut (.*);

    initial begin
        xclk = 1'b0;
        forever #(PERIOD / 2) xclk = ~xclk;
    end

    // 32-bit fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // buffer layout: a7, a3, a6..a4, a2..a0
    function automatic int remap(input int a);
        logic [7:0] v;
        v = a[7:0];
        return int'({v[7], v[3], v[6:4], v[2:0]});
    endfunction

    task automatic apb_xfer(input bit wr, input logic [3:0] a, input logic [31:0] d,
                            output logic [31:0] rd, output logic err);
        @(negedge xclk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = a;
        pwdata = d;
        @(negedge xclk);
        penable = 1'b1;   // access phase
        @(negedge xclk);
        rd = prdata;
        err = pslverr;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    // CTRL write spread over three pixel cycles, step 0 setup, 1 access, 2 idle
    task automatic ctrl_write_step(input int step, input logic [31:0] d);
        case (step)
            0: begin
                psel = 1'b1;
                pwrite = 1'b1;
                paddr = `CSC_REG_CTRL;
                pwdata = d;
            end
            1: penable = 1'b1;
            default: begin
                psel = 1'b0;
                penable = 1'b0;
                pwrite = 1'b0;
            end
        endcase
    endtask

    task automatic build_tile(input int t);
        logic [31:0] s;
        s = (t_seed[t] == 0) ? 32'h3bf3_a674 : t_seed[t];
        for (int i = 0; i < `CSC_TILE_PIX; i++) begin
            pix[i] = '0;
            case (t_src[t])
                0: for (int k = 0; k < 8; k++) begin
                    s = lfsr_next(s);
                    pix[i] = {pix[i][6:0], s[0]};   // one step per bit
                end
                1: pix[i] = t_seed[t][7:0];
                default: pix[i] = (i < t_seed[t][7:0]) ? 8'h00 :
                                  (i >= 256 - t_seed[t][15:8]) ? 8'hff : 8'h80;
            endcase
        end
    endtask

    // expected writes in output order, plus black/white counts
    task automatic model_tile(input int t);
        logic [31:0] c;
        int row, col, clr, ph, a, v, base;
        bit en;
        c = t_ctrl[t];
        cur0 = 0;
        cur255 = 0;
        for (int i = 0; i < 256; i++) begin
            cur0 += (pix[i] == 8'h00);
            cur255 += (pix[i] == 8'hff);
        end
        cur0 = (cur0 > 255) ? 255 : cur0;       // saturating
        cur255 = (cur255 > 255) ? 255 : cur255;
        en = c[31] && (c[2:0] == `CSC_MODE_MONO16 || c[2:0] == `CSC_MODE_JP4 ||
                       c[2:0] == `CSC_MODE_JP4DIFF);
        if (!en) return;
        pfo_exp++;
        ph = c[9:8];
        for (int i = 0; i < 256; i++) begin
            row = i / 16;
            col = i % 16;
            v = int'(pix[i]) - 128;
            if (c[2:0] == `CSC_MODE_MONO16) begin
                a = i;
            end else begin
                clr = ((row % 2) * 2 + col % 2) ^ ph;
                a = clr * 64 + (row / 2) * 8 + col / 2;
                if (c[2:0] == `CSC_MODE_JP4DIFF && !(clr == 0 || (c[5] && clr == 3))) begin
                    base = pix[(row - row % 2 + ph / 2) * 16 + col - col % 2 + ph % 2];
                    v = int'(pix[i]) - base;
                    if (c[4]) v = v >>> 1;   // floor halving
                end
            end
            exp_addr.push_back(remap(a));
            exp_val.push_back(v);
        end
    endtask

    task automatic check_counts(input int t, input int e0, input int c0, input int c255);
        assert (n000 == c0 && n255 == c255) else begin
            $display("MISMATCH %0t: tile %0d n000 %0d n255 %0d, expected %0d %0d",
                     $time, t, n000, n255, c0, c255);
            errors++;
        end
        $display("tile %0d ctrl %h: %s", t, t_ctrl[t], (errors == e0) ? "PASS" : "FAIL");
    endtask

    // output monitor, outputs are settled at the falling edge
    always @(negedge xclk) begin
        int ea, ev;
        if (rst_n) begin
            if (pre_first_out) pfo_seen++;
            if (ywe) begin
                assert (exp_addr.size() > 0) else begin
                    $display("unexpected buffer write at %0t to address %0d", $time, yaddrw);
                    errors++;
                end
                if (exp_addr.size() > 0) begin
                    ea = exp_addr.pop_front();
                    ev = exp_val.pop_front();
                    assert (int'(yaddrw) == ea && int'(signed_y) == ev) else begin
                        $display("MISMATCH %0t: addr %0d y %0d, expected addr %0d y %0d",
                                 $time, yaddrw, signed_y, ea, ev);
                        errors++;
                    end
                    hit[yaddrw]++;
                    tile_wr++;
                    if (tile_wr == 256) begin   // each address once per tile
                        for (int k = 0; k < 256; k++) begin
                            assert (hit[k] == 1) else begin
                                $display("address %0d written %0d times in one tile", k, hit[k]);
                                errors++;
                            end
                            hit[k] = 0;
                        end
                        tile_wr = 0;
                    end
                end
            end
        end
    end

    initial begin
        wait (rst_n === 1'b1);   // tile list complete by now
        #((n_tiles * 300 + 50) * PERIOD);
        $display("watchdog expired, the run did not finish in time");
        $display("Test failures found");
        $finish;
    end

    initial begin
        int fd, n, e0, p_t, p_e0, p0, p255;
        bit p_valid;
        string line;
        logic [31:0] c, sd, rd;
        int s, b;
        logic err;
        {psel, penable, pwrite, pre_first_in} = '0;
        paddr = '0;
        pwdata = '0;
        mb_din = '0;
        rst_n = 1'b0;
        {n_tiles, tile_wr, pfo_seen, pfo_exp, errors} = '0;
        p_valid = 1'b0;
        foreach (hit[k]) hit[k] = 0;
        fd = $fopen("dv/csc_stim.txt", "r");
        assert (fd != 0) else begin
            $display("cannot open the stimulus file");
            errors++;
        end
        while (fd != 0 && $fgets(line, fd) != 0) begin
            if (line.len() < 4 || line[0] == "/") continue;
            n = $sscanf(line, "%h %h %h %h", c, s, sd, b);
            if (n == 4 && n_tiles < 64) begin
                t_ctrl[n_tiles] = c;
                t_src[n_tiles] = s;
                t_seed[n_tiles] = sd;
                t_b2b[n_tiles] = b[0];
                n_tiles++;
            end
        end
        if (fd != 0) $fclose(fd);
        repeat (3) @(negedge xclk);
        rst_n = 1'b1;

        // register access
        e0 = errors;
        apb_xfer(1'b1, `CSC_REG_CTRL, 32'h8000_0133, rd, err);
        apb_xfer(1'b0, `CSC_REG_CTRL, '0, rd, err);
        assert (rd == 32'h8000_0133 && !err) else begin
            $display("MISMATCH %0t: CTRL read %h err %b", $time, rd, err);
            errors++;
        end
        apb_xfer(1'b0, 4'h4, '0, rd, err);
        assert (err) else begin
            $display("no slave error on a read of address 4");
            errors++;
        end
        $display("apb access: %s", (errors == e0) ? "PASS" : "FAIL");

        for (int t = 0; t < n_tiles; t++) begin
            e0 = errors;
            if (t == 0 || !t_b2b[t-1]) begin
                apb_xfer(1'b1, `CSC_REG_CTRL, t_ctrl[t], rd, err);
                @(negedge xclk);
                pre_first_in = 1'b1;
            end
            build_tile(t);
            model_tile(t);
            for (int i = 0; i < 256; i++) begin
                @(negedge xclk);
                mb_din = pix[i];
                pre_first_in = (i == 255) && t_b2b[t];   // next tile starts at once
                if (t_b2b[t] && t + 1 < n_tiles && i >= 8 && i <= 10) begin
                    ctrl_write_step(i - 8, t_ctrl[t + 1]);   // settings of the next tile
                end
                if (i == 20 && p_valid) begin   // previous tile drained, counts still held
                    check_counts(p_t, p_e0, p0, p255);
                    p_valid = 1'b0;
                end
            end
            if (t_b2b[t]) begin
                {p_t, p_e0, p0, p255} = {t, e0, cur0, cur255};
                p_valid = 1'b1;
            end else begin
                @(negedge xclk);
                pre_first_in = 1'b0;
                mb_din = '0;
                for (int k = 0; k < 40 && exp_addr.size() != 0; k++) @(negedge xclk);
                assert (exp_addr.size() == 0) else begin
                    $display("tile %0d timed out with %0d writes missing", t, exp_addr.size());
                    errors++;
                    exp_addr.delete();
                    exp_val.delete();
                end
                repeat (20) @(negedge xclk);   // room for a stray late write
                assert (pfo_seen == pfo_exp) else begin
                    $display("MISMATCH %0t: %0d tile starts out, expected %0d",
                             $time, pfo_seen, pfo_exp);
                    errors++;
                    pfo_seen = pfo_exp;
                end
                check_counts(t, e0, cur0, cur255);
            end
        end

        errors += i_dut.i_assert.n_fail;   // bound protocol checks
        $display("%0d tests run, %0d errors", n_tiles + 1, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== dv/csc_stim.txt ====
// ctrl(hex CTRL word) src(0 lfsr, 1 const seed[7:0], 2 seed[7:0] zeros + seed[15:8] whites)
// seed(hex, 0 = default lfsr seed) b2b(1 = next tile follows back to back)
80000002 0 00000000 0
80000003 0 12345678 0
80000103 0 9e3779b9 0
80000203 0 0badc0de 0
80000303 0 5a5aa5a5 0
80000004 0 00000000 0
80000014 0 13579bdf 0
80000024 0 2468ace0 0
80000134 0 7f4a7c15 1
80000234 0 c2b2ae35 0
80000002 1 00000000 0
80000002 1 000000ff 0
80000003 2 00002a11 0
00000002 0 31415926 0
80000007 0 27182818 0

// ==== src.f ====
+incdir+hdl
hdl/csc_pkg.sv
hdl/csc_apb_regs.sv
hdl/csc_mono16.sv
hdl/csc_jp4.sv
hdl/csconvert.sv
hdl/csc_top.sv
dv/csc_assert.sv
dv/csc_tb.sv

// ==== Bender.yml ====
package:
  name: csc

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/csc_pkg.sv
      - hdl/csc_apb_regs.sv
      - hdl/csc_mono16.sv
      - hdl/csc_jp4.sv
      - hdl/csconvert.sv
      - hdl/csc_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/csc_assert.sv
      - dv/csc_tb.sv
